// File: src/isa_pkg.sv
package isa_pkg;

    // two real ops; the upper two encodings are reserved and trap
    typedef enum logic [1:0] {
        OP_ADD  = 2'b00,
        OP_ADDI = 2'b01,
        OP_ILL2 = 2'b10,
        OP_ILL3 = 2'b11
    } opcode_e;

    typedef logic [2:0] arch_reg_t;

    // register form: rd <- rs1 + rs2
    typedef struct packed {
        opcode_e    opcode;
        arch_reg_t  rd;
        arch_reg_t  rs1;
        arch_reg_t  rs2;
        logic [4:0] unused;
    } r_fmt_t;

    // immediate form: rd <- rs1 + imm8
    typedef struct packed {
        opcode_e    opcode;
        arch_reg_t  rd;
        arch_reg_t  rs1;
        logic [7:0] imm8;
    } i_fmt_t;

    // opcode, rd and rs1 line up in both views,
    // the low byte is rs2 or imm8 depending on the opcode
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } inst_u;

endpackage

// File: src/core_pkg.sv
package core_pkg;

    localparam int ARCH_NUM   = 8;
    localparam int PREG_NUM   = 16;
    localparam int ROB_DEPTH  = 8;
    localparam int IBUF_DEPTH = 4;

    localparam int PREG_W     = $clog2(PREG_NUM);
    localparam int ROB_IDX_W  = $clog2(ROB_DEPTH);
    localparam int IBUF_PTR_W = $clog2(IBUF_DEPTH);

    // arch reg r starts on preg r, the rest are free
    localparam logic [PREG_NUM-1:0] FREE_INIT =
        {{(PREG_NUM - ARCH_NUM){1'b1}}, {ARCH_NUM{1'b0}}};

    typedef logic [PREG_W-1:0]     preg_t;
    typedef logic [ROB_IDX_W-1:0]  rob_idx_t;
    typedef logic [ROB_IDX_W:0]    rob_cnt_t;
    typedef logic [IBUF_PTR_W-1:0] ibuf_ptr_t;
    typedef logic [IBUF_PTR_W:0]   ibuf_cnt_t;
    typedef logic [7:0]            pc_t;

    typedef struct packed {
        pc_t         pc;
        logic [15:0] inst;
    } fetch_t;

    typedef struct packed {
        pc_t                pc;
        isa_pkg::arch_reg_t rd;
        isa_pkg::arch_reg_t rs1;
        isa_pkg::arch_reg_t rs2;
        logic [7:0]         imm;
        logic               is_imm;
        logic               illegal;
    } dec_t;

    typedef struct packed {
        rob_idx_t   rob_idx;
        pc_t        pc;
        preg_t      psrc1;
        preg_t      psrc2;
        preg_t      pdst;
        logic [7:0] imm;
        logic       is_imm;
    } disp_t;

    typedef struct packed {
        rob_idx_t rob_idx;
        logic     except;
    } wb_t;

    typedef struct packed {
        rob_idx_t           rob_idx;
        pc_t                pc;
        isa_pkg::arch_reg_t arch_rd;
        preg_t              pdst;
        preg_t              old_pdst;
        logic               has_dst;
    } commit_t;

    // cause 0 = illegal opcode, 1 = exception reported at writeback
    typedef struct packed {
        pc_t      pc;
        rob_idx_t rob_idx;
        logic     cause;
    } squash_t;

endpackage

// File: src/inst_buffer.sv
`timescale 1ns/10ps

module inst_buffer (
    input  logic             clk,
    input  logic             i_rst,
    input  logic             i_flush,

    input  logic             i_enq_vld,
    input  core_pkg::fetch_t i_enq,
    output logic             o_enq_rdy,

    output logic             o_deq_vld,
    output core_pkg::fetch_t o_deq,
    input  logic             i_deq
);
    import core_pkg::*;

    fetch_t    mem [IBUF_DEPTH];
    ibuf_ptr_t wr_ptr_q;
    ibuf_ptr_t rd_ptr_q;
    ibuf_cnt_t count_q;
    logic      enq_fire;
    logic      deq_fire;

    assign o_enq_rdy = (count_q != ibuf_cnt_t'(IBUF_DEPTH));
    assign o_deq_vld = (count_q != '0);
    assign o_deq     = mem[rd_ptr_q];

    assign enq_fire = i_enq_vld && o_enq_rdy;
    assign deq_fire = i_deq && o_deq_vld;

    always_ff @(posedge clk) begin
        if (i_rst || i_flush) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (enq_fire) begin
                wr_ptr_q <= wr_ptr_q + ibuf_ptr_t'(1);
            end
            if (deq_fire) begin
                rd_ptr_q <= rd_ptr_q + ibuf_ptr_t'(1);
            end
            count_q <= count_q + ibuf_cnt_t'(enq_fire) - ibuf_cnt_t'(deq_fire);
        end
    end

    // storage only, pointers decide what is live
    always_ff @(posedge clk) begin
        if (enq_fire) begin
            mem[wr_ptr_q] <= i_enq;
        end
    end

endmodule

// File: src/decode.sv
`timescale 1ns/10ps

module decode (
    input  logic             clk,
    input  logic             i_rst,
    input  logic             i_flush,

    input  logic             i_inst_vld,
    input  core_pkg::fetch_t i_inst,
    output logic             o_deq,

    input  logic             i_stall,
    output logic             o_dec_vld,
    output core_pkg::dec_t   o_dec
);
    import isa_pkg::*;
    import core_pkg::*;

    inst_u word;
    dec_t  dec_d;
    logic  dec_vld_q;
    dec_t  dec_q;
    logic  can_load;

    // stage refills when empty or when rename takes the current one
    assign can_load  = !dec_vld_q || !i_stall;
    assign o_deq     = i_inst_vld && can_load;
    assign o_dec_vld = dec_vld_q;
    assign o_dec     = dec_q;

    always_comb begin
        word          = i_inst.inst;
        dec_d.pc      = i_inst.pc;
        dec_d.rd      = word.r.rd;
        dec_d.rs1     = word.r.rs1;
        // rs2 only means something for ADD, imm only for ADDI
        dec_d.rs2     = word.r.rs2;
        dec_d.imm     = word.i.imm8;
        dec_d.is_imm  = (word.i.opcode == OP_ADDI);
        dec_d.illegal = (word.r.opcode == OP_ILL2) || (word.r.opcode == OP_ILL3);
    end

    always_ff @(posedge clk) begin
        if (i_rst || i_flush) begin
            dec_vld_q <= 1'b0;
        end else if (can_load) begin
            dec_vld_q <= i_inst_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (o_deq) begin
            dec_q <= dec_d;
        end
    end

endmodule

// File: src/rename.sv
`timescale 1ns/10ps

module rename (
    input  logic               clk,
    input  logic               i_rst,

    input  logic               i_dec_vld,
    input  core_pkg::dec_t     i_dec,
    output logic               o_stall,

    output logic               o_ren_vld,
    output core_pkg::disp_t    o_ren,
    output logic               o_ren_illegal,
    // rob needs these to release the old mapping at commit
    output isa_pkg::arch_reg_t o_ren_rd,
    output core_pkg::preg_t    o_ren_old_pdst,
    input  logic               i_take,

    input  logic               i_commit_vld,
    input  core_pkg::commit_t  i_commit,
    input  logic               i_squash_vld
);
    import core_pkg::*;

    preg_t               spec_map_q [ARCH_NUM];
    preg_t               cmt_map_q  [ARCH_NUM];
    logic [PREG_NUM-1:0] spec_free_q;
    logic [PREG_NUM-1:0] cmt_free_q;
    logic [PREG_NUM-1:0] spec_free_d;

    logic  ren_vld_q;
    disp_t ren_q;
    logic  ren_ill_q;
    logic [2:0] ren_rd_q;
    preg_t ren_old_q;

    preg_t free_idx;
    logic  any_free;
    logic  ren_free;
    logic  load;
    logic  alloc;

    // lowest numbered free preg wins
    always_comb begin
        free_idx = '0;
        for (int p = PREG_NUM - 1; p >= 0; p--) begin
            if (spec_free_q[p]) begin
                free_idx = preg_t'(p);
            end
        end
    end

    assign any_free = |spec_free_q;
    assign ren_free = !ren_vld_q || i_take;
    assign o_stall  = !(ren_free && (i_dec.illegal || any_free));
    assign load     = i_dec_vld && !o_stall;
    assign alloc    = load && !i_dec.illegal;

    // a commit and an allocation can land in the same cycle
    always_comb begin
        spec_free_d = spec_free_q;
        if (i_commit_vld && i_commit.has_dst) begin
            spec_free_d[i_commit.old_pdst] = 1'b1;
        end
        if (alloc) begin
            spec_free_d[free_idx] = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int r = 0; r < ARCH_NUM; r++) begin
                spec_map_q[r] <= preg_t'(r);
                cmt_map_q[r]  <= preg_t'(r);
            end
            spec_free_q <= FREE_INIT;
            cmt_free_q  <= FREE_INIT;
            ren_vld_q   <= 1'b0;
        end else begin
            if (i_commit_vld && i_commit.has_dst) begin
                cmt_map_q[i_commit.arch_rd]   <= i_commit.pdst;
                cmt_free_q[i_commit.old_pdst] <= 1'b1;
                cmt_free_q[i_commit.pdst]     <= 1'b0;
            end
            if (i_squash_vld) begin
                // back to the architectural view
                spec_map_q  <= cmt_map_q;
                spec_free_q <= cmt_free_q;
                ren_vld_q   <= 1'b0;
            end else begin
                if (alloc) begin
                    spec_map_q[i_dec.rd] <= free_idx;
                end
                spec_free_q <= spec_free_d;
                if (ren_free) begin
                    ren_vld_q <= load;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            ren_q.rob_idx <= '0;
            ren_q.pc      <= i_dec.pc;
            ren_q.psrc1   <= spec_map_q[i_dec.rs1];
            ren_q.psrc2   <= spec_map_q[i_dec.rs2];
            ren_q.pdst    <= i_dec.illegal ? '0 : free_idx;
            ren_q.imm     <= i_dec.imm;
            ren_q.is_imm  <= i_dec.is_imm;
            ren_ill_q     <= i_dec.illegal;
            ren_rd_q      <= i_dec.rd;
            ren_old_q     <= spec_map_q[i_dec.rd];
        end
    end

    assign o_ren_vld      = ren_vld_q;
    assign o_ren          = ren_q;
    assign o_ren_illegal  = ren_ill_q;
    assign o_ren_rd       = ren_rd_q;
    assign o_ren_old_pdst = ren_old_q;

endmodule

// File: src/rob.sv
`timescale 1ns/10ps

module rob (
    input  logic               clk,
    input  logic               i_rst,

    input  logic               i_enq_vld,
    input  core_pkg::disp_t    i_enq,
    input  logic               i_enq_illegal,
    input  isa_pkg::arch_reg_t i_enq_rd,
    input  core_pkg::preg_t    i_enq_old_pdst,
    output logic               o_can_enq,
    output core_pkg::rob_idx_t o_alloc_idx,

    input  logic               i_wb_vld,
    input  core_pkg::wb_t      i_wb,

    output logic               o_commit_vld,
    output core_pkg::commit_t  o_commit,
    output logic               o_squash_vld,
    output core_pkg::squash_t  o_squash
);
    import core_pkg::*;

    pc_t        pc_q     [ROB_DEPTH];
    logic [2:0] rd_q     [ROB_DEPTH];
    preg_t      pdst_q   [ROB_DEPTH];
    preg_t      old_q    [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] cause_q;
    logic [ROB_DEPTH-1:0] done_q;
    logic [ROB_DEPTH-1:0] fault_q;

    rob_idx_t head_q;
    rob_idx_t tail_q;
    rob_cnt_t count_q;
    logic     head_done;
    logic     enq_fire;

    assign head_done    = (count_q != '0) && done_q[head_q];
    assign o_commit_vld = head_done && !fault_q[head_q];
    assign o_squash_vld = head_done && fault_q[head_q];

    // nothing enters while the window is being thrown away
    assign o_can_enq   = (count_q != rob_cnt_t'(ROB_DEPTH)) && !o_squash_vld;
    assign o_alloc_idx = tail_q;
    assign enq_fire    = i_enq_vld && o_can_enq;

    always_comb begin
        o_commit.rob_idx  = head_q;
        o_commit.pc       = pc_q[head_q];
        o_commit.arch_rd  = rd_q[head_q];
        o_commit.pdst     = pdst_q[head_q];
        o_commit.old_pdst = old_q[head_q];
        // ADD and ADDI both write rd
        o_commit.has_dst  = 1'b1;

        o_squash.pc      = pc_q[head_q];
        o_squash.rob_idx = head_q;
        o_squash.cause   = cause_q[head_q];
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            done_q  <= '0;
            fault_q <= '0;
        end else if (o_squash_vld) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (enq_fire) begin
                tail_q <= tail_q + rob_idx_t'(1);
                // illegal ops arrive finished and already faulting
                done_q[tail_q]  <= i_enq_illegal;
                fault_q[tail_q] <= i_enq_illegal;
            end
            if (i_wb_vld) begin
                done_q[i_wb.rob_idx] <= 1'b1;
                if (i_wb.except) begin
                    fault_q[i_wb.rob_idx] <= 1'b1;
                end
            end
            if (o_commit_vld) begin
                head_q <= head_q + rob_idx_t'(1);
            end
            count_q <= count_q + rob_cnt_t'(enq_fire) - rob_cnt_t'(o_commit_vld);
        end
    end

    always_ff @(posedge clk) begin
        if (enq_fire) begin
            pc_q[tail_q]    <= i_enq.pc;
            rd_q[tail_q]    <= i_enq_rd;
            pdst_q[tail_q]  <= i_enq.pdst;
            old_q[tail_q]   <= i_enq_old_pdst;
            cause_q[tail_q] <= 1'b0;
        end
        if (i_wb_vld && i_wb.except) begin
            cause_q[i_wb.rob_idx] <= 1'b1;
        end
    end

endmodule

// File: src/ctrl_block.sv
`timescale 1ns/10ps

// fetch queue -> decode -> rename/dispatch, with the rob beside dispatch
module ctrl_block (
    input  logic              clk,
    input  logic              i_rst,

    input  logic              i_fetch_vld,
    input  core_pkg::fetch_t  i_fetch,
    output logic              o_fetch_rdy,

    output logic              o_disp_vld,
    output core_pkg::disp_t   o_disp,
    input  logic              i_disp_rdy,

    input  logic              i_wb_vld,
    input  core_pkg::wb_t     i_wb,

    output logic              o_commit_vld,
    output core_pkg::commit_t o_commit,

    output logic              o_squash_vld,
    output core_pkg::squash_t o_squash
);
    import core_pkg::*;

    logic       ibuf_vld;
    fetch_t     ibuf_data;
    logic       dec_deq;
    logic       dec_vld;
    dec_t       dec_info;
    logic       ren_stall;
    logic       ren_vld;
    disp_t      ren_info;
    logic       ren_illegal;
    logic [2:0] ren_rd;
    preg_t      ren_old_pdst;
    logic       ren_take;
    logic       rob_can_enq;
    rob_idx_t   alloc_idx;

    // illegal ops only need a rob slot, never the execution side
    assign ren_take   = ren_vld && rob_can_enq && (ren_illegal || i_disp_rdy);
    assign o_disp_vld = ren_vld && !ren_illegal && rob_can_enq;

    always_comb begin
        o_disp         = ren_info;
        o_disp.rob_idx = alloc_idx;
    end

    inst_buffer u_inst_buffer (
        .clk       (clk),
        .i_rst     (i_rst),
        .i_flush   (o_squash_vld),
        .i_enq_vld (i_fetch_vld),
        .i_enq     (i_fetch),
        .o_enq_rdy (o_fetch_rdy),
        .o_deq_vld (ibuf_vld),
        .o_deq     (ibuf_data),
        .i_deq     (dec_deq)
    );

    decode u_decode (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_flush    (o_squash_vld),
        .i_inst_vld (ibuf_vld),
        .i_inst     (ibuf_data),
        .o_deq      (dec_deq),
        .i_stall    (ren_stall),
        .o_dec_vld  (dec_vld),
        .o_dec      (dec_info)
    );

    rename u_rename (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_dec_vld      (dec_vld),
        .i_dec          (dec_info),
        .o_stall        (ren_stall),
        .o_ren_vld      (ren_vld),
        .o_ren          (ren_info),
        .o_ren_illegal  (ren_illegal),
        .o_ren_rd       (ren_rd),
        .o_ren_old_pdst (ren_old_pdst),
        .i_take         (ren_take),
        .i_commit_vld   (o_commit_vld),
        .i_commit       (o_commit),
        .i_squash_vld   (o_squash_vld)
    );

    rob u_rob (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_enq_vld      (ren_take),
        .i_enq          (ren_info),
        .i_enq_illegal  (ren_illegal),
        .i_enq_rd       (ren_rd),
        .i_enq_old_pdst (ren_old_pdst),
        .o_can_enq      (rob_can_enq),
        .o_alloc_idx    (alloc_idx),
        .i_wb_vld       (i_wb_vld),
        .i_wb           (i_wb),
        .o_commit_vld   (o_commit_vld),
        .o_commit       (o_commit),
        .o_squash_vld   (o_squash_vld),
        .o_squash       (o_squash)
    );

endmodule

// File: test/ctrl_block_checker.sv
`timescale 1ns/10ps

module ctrl_block_checker (
    input logic            clk,
    input logic            i_rst,
    input logic            o_fetch_rdy,
    input logic            o_disp_vld,
    input core_pkg::disp_t o_disp,
    input logic            i_disp_rdy,
    input logic            o_commit_vld,
    input logic            o_squash_vld
);

    // a squash empties rename and the rob in one edge
    squash_flushes: assert property (@(posedge clk) disable iff (i_rst)
        o_squash_vld |=> !(o_disp_vld || o_commit_vld || o_squash_vld))
        else $error("output valid high in the cycle after a squash");

    // a stalled dispatch keeps its payload until taken or squashed
    disp_stable: assert property (@(posedge clk) disable iff (i_rst)
        (o_disp_vld && !i_disp_rdy && !o_squash_vld)
        |=> (o_squash_vld || (o_disp_vld && $stable(o_disp))))
        else $error("o_disp changed while stalled");

    // one reset edge clears every output valid and opens the fetch queue
    quiet_in_reset: assert property (@(posedge clk)
        (i_rst && $past(i_rst))
        |-> (o_fetch_rdy && !(o_disp_vld || o_commit_vld || o_squash_vld)))
        else $error("output valid high or fetch not ready during reset");

endmodule

// File: test/ctrl_block_monitor.sv
`timescale 1ns/10ps

module ctrl_block_monitor (
    input  logic              clk,
    input  logic              i_rst,
    input  logic              i_fetch_vld,
    input  core_pkg::fetch_t  i_fetch,
    input  logic              o_fetch_rdy,
    input  logic              o_disp_vld,
    input  core_pkg::disp_t   o_disp,
    input  logic              i_disp_rdy,
    input  logic              i_wb_vld,
    input  core_pkg::wb_t     i_wb,
    input  logic              o_commit_vld,
    input  core_pkg::commit_t o_commit,
    input  logic              o_squash_vld,
    input  core_pkg::squash_t o_squash,
    output int                o_errors,
    output int                o_disps,
    output int                o_commits,
    output int                o_sq_ill,
    output int                o_sq_exc,
    output logic              o_idle
);
    import isa_pkg::*;
    import core_pkg::*;

    typedef struct packed {
        rob_idx_t  idx;
        pc_t       pc;
        arch_reg_t rd;
        preg_t     pdst;
        preg_t     old_pdst;
        logic      illegal;
        logic      done;
        logic      except;
    } entry_t;

    fetch_t              acc_q [$];
    entry_t              rob_m [$];
    preg_t               spec_map [ARCH_NUM];
    preg_t               cmt_map [ARCH_NUM];
    logic [PREG_NUM-1:0] spec_free;
    logic [PREG_NUM-1:0] cmt_free;
    // cycle in which each preg last became free
    int                  free_stamp [PREG_NUM];
    int                  cycle = 0;
    int                  last_take;
    rob_idx_t            next_idx;

    initial begin
        o_errors  = 0;
        o_disps   = 0;
        o_commits = 0;
        o_sq_ill  = 0;
        o_sq_exc  = 0;
        o_idle    = 1'b1;
    end

    task automatic mismatch(string name, logic [31:0] exp, logic [31:0] act);
        $display("Mismatch at %0t: %s expected %0h, got %0h", $time, name, exp, act);
        o_errors++;
    endtask

    task automatic complain(string what);
        $display("Error at %0t: %s", $time, what);
        o_errors++;
    endtask

    task automatic reset_model();
        for (int r = 0; r < ARCH_NUM; r++) begin
            spec_map[r] = preg_t'(r);
            cmt_map[r]  = preg_t'(r);
        end
        spec_free = FREE_INIT;
        cmt_free  = FREE_INIT;
        for (int p = 0; p < PREG_NUM; p++) begin
            free_stamp[p] = 0;
        end
        acc_q.delete();
        rob_m.delete();
        next_idx  = '0;
        last_take = cycle;
    endtask

    task automatic squash_window();
        entry_t e;
        logic   found;
        found = 1'b1;
        e     = '0;
        if (rob_m.size() != 0) begin
            e = rob_m[0];
        end else if (acc_q.size() != 0 && acc_q[0].inst[15]) begin
            // illegal op that entered the rob without a visible dispatch
            e.idx     = next_idx;
            e.pc      = acc_q[0].pc;
            e.illegal = 1'b1;
        end else begin
            found = 1'b0;
            complain("squash with no faulting instruction at the head");
        end
        if (found) begin
            if (!e.illegal && !(e.done && e.except)) begin
                complain("squash for an entry that did not fault");
            end
            if (o_squash.pc != e.pc) mismatch("o_squash.pc", e.pc, o_squash.pc);
            if (o_squash.rob_idx != e.idx) mismatch("o_squash.rob_idx", e.idx, o_squash.rob_idx);
            if (o_squash.cause != !e.illegal) mismatch("o_squash.cause", !e.illegal, o_squash.cause);
            if (e.illegal) o_sq_ill++;
            else o_sq_exc++;
        end
        for (int p = 0; p < PREG_NUM; p++) begin
            if (cmt_free[p] && !spec_free[p]) free_stamp[p] = cycle;
        end
        spec_map  = cmt_map;
        spec_free = cmt_free;
        acc_q.delete();
        rob_m.delete();
        next_idx  = '0;
        last_take = cycle;
    endtask

    task automatic match_dispatch();
        fetch_t    f;
        entry_t    e;
        arch_reg_t rd;
        arch_reg_t rs1;
        arch_reg_t rs2;
        // illegal ops ahead of this one took rob slots silently
        while (acc_q.size() != 0 && acc_q[0].inst[15]) begin
            f = acc_q.pop_front();
            e = '0;
            e.idx = next_idx;
            e.pc = f.pc;
            e.illegal = 1'b1;
            e.done = 1'b1;
            rob_m.push_back(e);
            next_idx++;
        end
        if (acc_q.size() == 0) begin
            complain("dispatch with no accepted instruction left");
            return;
        end
        f   = acc_q.pop_front();
        rd  = f.inst[13:11];
        rs1 = f.inst[10:8];
        rs2 = f.inst[7:5];
        o_disps++;
        if (o_disp.pc != f.pc) mismatch("o_disp.pc", f.pc, o_disp.pc);
        if (o_disp.imm != f.inst[7:0]) mismatch("o_disp.imm", f.inst[7:0], o_disp.imm);
        if (o_disp.is_imm != f.inst[14]) mismatch("o_disp.is_imm", f.inst[14], o_disp.is_imm);
        if (o_disp.rob_idx != next_idx) mismatch("o_disp.rob_idx", next_idx, o_disp.rob_idx);
        if (o_disp.psrc1 != spec_map[rs1]) mismatch("o_disp.psrc1", spec_map[rs1], o_disp.psrc1);
        if (o_disp.psrc2 != spec_map[rs2]) mismatch("o_disp.psrc2", spec_map[rs2], o_disp.psrc2);
        if (!spec_free[o_disp.pdst]) begin
            complain($sformatf("o_disp.pdst %0d is not a free register", o_disp.pdst));
        end
        // a lower preg free since before the rename must have been picked
        for (int p = 0; p < int'(o_disp.pdst); p++) begin
            if (spec_free[p] && free_stamp[p] < last_take) begin
                mismatch("o_disp.pdst", p, o_disp.pdst);
                break;
            end
        end
        e = '0;
        e.idx = next_idx;
        e.pc = f.pc;
        e.rd = rd;
        e.pdst = o_disp.pdst;
        e.old_pdst = spec_map[rd];
        rob_m.push_back(e);
        spec_map[rd] = o_disp.pdst;
        spec_free[o_disp.pdst] = 1'b0;
        next_idx++;
        last_take = cycle;
    endtask

    task automatic retire_head();
        entry_t e;
        if (rob_m.size() == 0) begin
            complain("commit with no outstanding instruction");
            return;
        end
        e = rob_m.pop_front();
        o_commits++;
        if (e.illegal || !e.done || e.except) complain("commit of an entry not finished cleanly");
        if (o_commit.rob_idx != e.idx) mismatch("o_commit.rob_idx", e.idx, o_commit.rob_idx);
        if (o_commit.pc != e.pc) mismatch("o_commit.pc", e.pc, o_commit.pc);
        if (o_commit.arch_rd != e.rd) mismatch("o_commit.arch_rd", e.rd, o_commit.arch_rd);
        if (o_commit.pdst != e.pdst) mismatch("o_commit.pdst", e.pdst, o_commit.pdst);
        if (o_commit.old_pdst != e.old_pdst) begin
            mismatch("o_commit.old_pdst", e.old_pdst, o_commit.old_pdst);
        end
        if (!o_commit.has_dst) mismatch("o_commit.has_dst", 1, o_commit.has_dst);
        cmt_map[e.rd]       = e.pdst;
        cmt_free[e.old_pdst] = 1'b1;
        cmt_free[e.pdst]     = 1'b0;
        spec_free[e.old_pdst] = 1'b1;
        free_stamp[e.old_pdst] = cycle;
    endtask

    task automatic mark_done();
        for (int i = 0; i < rob_m.size(); i++) begin
            if (!rob_m[i].illegal && rob_m[i].idx == i_wb.rob_idx) begin
                rob_m[i].done   = 1'b1;
                rob_m[i].except = i_wb.except;
                return;
            end
        end
        complain("writeback to an entry that is not outstanding");
    endtask

    // sampled mid-cycle so each event belongs to the next rising edge
    always @(negedge clk) begin
        cycle++;
        if (i_rst) begin
            reset_model();
        end else if (o_squash_vld) begin
            squash_window();
        end else begin
            if (o_disp_vld && i_disp_rdy) match_dispatch();
            if (o_commit_vld) retire_head();
            if (i_wb_vld) mark_done();
            if (i_fetch_vld && o_fetch_rdy) acc_q.push_back(i_fetch);
        end
        o_idle = (acc_q.size() == 0) && (rob_m.size() == 0);
    end

endmodule

// File: test/tb_ctrl_block.sv
`timescale 1ns/10ps

module tb_ctrl_block;
    import isa_pkg::*;
    import core_pkg::*;

    logic    clk;
    logic    i_rst;
    logic    i_fetch_vld;
    fetch_t  i_fetch;
    logic    o_fetch_rdy;
    logic    o_disp_vld;
    disp_t   o_disp;
    logic    i_disp_rdy;
    logic    i_wb_vld;
    wb_t     i_wb;
    logic    o_commit_vld;
    commit_t o_commit;
    logic    o_squash_vld;
    squash_t o_squash;

    int mon_errors;
    int disps;
    int commits;
    int sq_ill;
    int sq_exc;
    logic idle;

    int seed = 67;
    int fetch_pct;
    int disp_pct;
    int wb_pct;
    int ill_pct;
    int exc_pct;
    int tb_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int err_mark;
    int mark_a;
    int mark_b;
    pc_t next_pc = '0;
    rob_idx_t pend [$];

    ctrl_block dut (.*);

    ctrl_block_monitor u_monitor (
        .o_errors (mon_errors),
        .o_disps  (disps),
        .o_commits(commits),
        .o_sq_ill (sq_ill),
        .o_sq_exc (sq_exc),
        .o_idle   (idle),
        .*
    );

    bind ctrl_block ctrl_block_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic chance(int pct);
        return (($random(seed) & 32'h7fffffff) % 100) < pct;
    endfunction

    // setting the top opcode bit makes the word illegal
    function automatic logic [15:0] random_word();
        logic [15:0] w;
        w = 16'($random(seed));
        w[15] = chance(ill_pct);
        return w;
    endfunction

    task automatic complain(string what);
        $display("Error at %0t: %s", $time, what);
        tb_errors++;
    endtask

    task automatic step();
        logic     fetch_fire;
        logic     disp_fire;
        logic     squash_seen;
        rob_idx_t disp_idx;
        int       k;
        @(negedge clk);
        fetch_fire  = i_fetch_vld && o_fetch_rdy;
        disp_fire   = o_disp_vld && i_disp_rdy;
        disp_idx    = o_disp.rob_idx;
        squash_seen = o_squash_vld;
        @(posedge clk);
        #1;
        if (squash_seen) pend.delete();
        else if (disp_fire) pend.push_back(disp_idx);
        if (fetch_fire) next_pc++;
        i_fetch_vld  = chance(fetch_pct);
        i_fetch.pc   = next_pc;
        i_fetch.inst = random_word();
        i_disp_rdy   = chance(disp_pct);
        i_wb_vld     = 1'b0;
        // writebacks go out of order to any dispatched entry
        if (pend.size() != 0 && chance(wb_pct)) begin
            k = ($random(seed) & 32'h7fffffff) % pend.size();
            i_wb.rob_idx = pend[k];
            i_wb.except  = chance(exc_pct);
            pend.delete(k);
            i_wb_vld = 1'b1;
        end
    endtask

    task automatic set_mix(int f, int d, int w, int il, int ex);
        fetch_pct = f;
        disp_pct  = d;
        wb_pct    = w;
        ill_pct   = il;
        exc_pct   = ex;
    endtask

    task automatic drain();
        int n;
        set_mix(0, 100, 60, 0, 0);
        n = 0;
        step();
        while (!(idle && pend.size() == 0) && n < 3000) begin
            step();
            n++;
        end
        if (n >= 3000) complain("pipeline did not drain within 3000 cycles");
    endtask

    task automatic end_test(string name);
        int errs;
        errs = mon_errors + tb_errors - err_mark;
        tests_run++;
        if (errs != 0) tests_failed++;
        $display("test %s: %0d errors, %0d dispatched, %0d committed, %0d squashed",
                 name, errs, disps, commits, sq_ill + sq_exc);
        err_mark = mon_errors + tb_errors;
    endtask

    initial begin
        int n;
        i_rst       = 1'b1;
        i_fetch_vld = 1'b0;
        i_fetch     = '0;
        i_disp_rdy  = 1'b0;
        i_wb_vld    = 1'b0;
        i_wb        = '0;
        set_mix(0, 0, 0, 0, 0);
        repeat (16) @(posedge clk);
        #1;
        i_rst = 1'b0;
        err_mark = 0;

        // mixed traffic with illegal ops and exception writebacks
        mark_a = sq_ill;
        mark_b = sq_exc;
        set_mix(70, 80, 50, 10, 5);
        repeat (800) step();
        drain();
        if (sq_ill == mark_a) complain("no squash for an illegal opcode was seen");
        if (sq_exc == mark_b) complain("no squash for a writeback exception was seen");
        end_test("random_traffic");

        // dispatch held off until fetch sees the queue full
        set_mix(90, 0, 50, 0, 0);
        n = 0;
        step();
        while (o_fetch_rdy && n < 60) begin
            step();
            n++;
        end
        if (o_fetch_rdy) complain("o_fetch_rdy never fell under back-pressure");
        // the full pipe stays parked while dispatch is blocked
        n = 0;
        repeat (30) begin
            step();
            if (o_fetch_rdy || !o_disp_vld) n++;
        end
        if (n != 0) complain("fetch reopened or dispatch dropped while i_disp_rdy was low");
        set_mix(70, 60, 50, 0, 0);
        repeat (300) step();
        drain();
        end_test("back_pressure");

        // no writebacks, so rob slots and pregs run out
        mark_a = disps;
        set_mix(100, 100, 0, 0, 0);
        repeat (80) step();
        mark_b = disps;
        repeat (40) step();
        if (disps - mark_a > ROB_DEPTH) complain("more dispatches than rob entries");
        if (disps != mark_b) complain("dispatch did not stall without writebacks");
        drain();
        end_test("resource_exhaustion");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 mon_errors + tb_errors);
        if (tests_failed == 0 && mon_errors + tb_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: sim.f
src/isa_pkg.sv
src/core_pkg.sv
src/inst_buffer.sv
src/decode.sv
src/rename.sv
src/rob.sv
src/ctrl_block.sv
test/ctrl_block_checker.sv
test/ctrl_block_monitor.sv
test/tb_ctrl_block.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_ctrl_block -f sim.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

grep -qx "all tests passed" sim.log
